//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eth_afu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: build
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- afu_csr.sv
// --------------------------------------
// AFU CSR block
// MMIO decode, CSR storage and a two stage
// read response pipeline
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module afu_csr (
    input  logic                   clk,
    input  logic                   pck_cp2af_softReset_T1,
    input  eth_afu_pkg::mmio_req_t req,
    output eth_afu_pkg::mmio_rsp_t rsp,
    output logic [31:0]            eth_ctrl,
    output eth_afu_pkg::mac_data_t eth_wr_data,
    input  eth_afu_pkg::mac_data_t eth_rd_data,
    output logic                   init_start,
    input  logic                   init_done
);

    // Register slot is the 8 byte word index
    logic [3:0] slot;

    // CSR storage
    eth_afu_pkg::mmio_data_t init_q;
    eth_afu_pkg::mmio_data_t scratch_q;
    logic [31:0]             eth_ctrl_q;
    eth_afu_pkg::mac_data_t  eth_wr_q;

    // Read pipeline
    eth_afu_pkg::mmio_data_t rd_mux;
    eth_afu_pkg::mmio_data_t rd_data_t1;
    eth_afu_pkg::mmio_tid_t  tid_t1;
    logic                    ren_t1;
    eth_afu_pkg::mmio_data_t rsp_data_t2;
    eth_afu_pkg::mmio_tid_t  rsp_tid_t2;
    logic                    rsp_valid_t2;

    assign slot = req.addr[6:3];

    // --------------------------------------
    // CSR writes
    always_ff @(posedge clk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            init_q     <= '0;
            scratch_q  <= '0;
            eth_ctrl_q <= '0;
            eth_wr_q   <= '0;
        end
        else if (req.wr_valid)
        begin
            case (slot)
                eth_afu_pkg::CSR_INIT[6:3]:        init_q     <= req.data;
                eth_afu_pkg::CSR_ETH_CTRL[6:3]:    eth_ctrl_q <= req.data[31:0];
                eth_afu_pkg::CSR_ETH_WR_DATA[6:3]: eth_wr_q   <= req.data[31:0];
                eth_afu_pkg::CSR_SCRATCH[6:3]:     scratch_q  <= req.data;
                default: ;
            endcase
        end
    end

    // --------------------------------------
    // Read data select
    always_comb
    begin
        case (slot)
            eth_afu_pkg::CSR_DFH[6:3]:         rd_mux = eth_afu_pkg::DFH_VALUE;
            eth_afu_pkg::CSR_ID_L[6:3]:        rd_mux = eth_afu_pkg::AFU_ID_LO;
            eth_afu_pkg::CSR_ID_H[6:3]:        rd_mux = eth_afu_pkg::AFU_ID_HI;
            // Bit 1 reports bring-up status
            eth_afu_pkg::CSR_INIT[6:3]:        rd_mux = {init_q[63:2], init_done, init_q[0]};
            eth_afu_pkg::CSR_ETH_CTRL[6:3]:    rd_mux = {32'b0, eth_ctrl_q};
            eth_afu_pkg::CSR_ETH_WR_DATA[6:3]: rd_mux = {32'b0, eth_wr_q};
            eth_afu_pkg::CSR_ETH_RD_DATA[6:3]: rd_mux = {32'b0, eth_rd_data};
            eth_afu_pkg::CSR_SCRATCH[6:3]:     rd_mux = scratch_q;
            default:                           rd_mux = '0;
        endcase
    end

    // Valid path of both stages
    always_ff @(posedge clk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            ren_t1       <= 1'b0;
            rsp_valid_t2 <= 1'b0;
        end
        else
        begin
            ren_t1       <= req.rd_valid;
            rsp_valid_t2 <= ren_t1;
        end
    end

    // Tid and data follow each read down the pipe
    always_ff @(posedge clk)
    begin
        rd_data_t1  <= rd_mux;
        tid_t1      <= req.tid;
        rsp_data_t2 <= rd_data_t1;
        rsp_tid_t2  <= tid_t1;
    end

    assign rsp.valid   = rsp_valid_t2;
    assign rsp.tid     = rsp_tid_t2;
    assign rsp.data    = rsp_data_t2;

    // Mailbox and init outputs
    assign eth_ctrl    = eth_ctrl_q;
    assign eth_wr_data = eth_wr_q;
    assign init_start  = init_q[0];

endmodule

`default_nettype wire

//--- ccip_mmio_reg.sv
// --------------------------------------
// MMIO boundary register stage
// One flop each way between host and CSR block
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module ccip_mmio_reg (
    input  logic                   clk,
    input  logic                   pck_cp2af_softReset_T1,
    input  eth_afu_pkg::mmio_req_t req_in,
    output eth_afu_pkg::mmio_req_t req_q,
    input  eth_afu_pkg::mmio_rsp_t rsp_d,
    output eth_afu_pkg::mmio_rsp_t rsp_out
);

    // Strobes, cleared by reset
    logic req_wr_q;
    logic req_rd_q;
    logic rsp_valid_q;

    // Payloads, free running
    eth_afu_pkg::mmio_req_t req_pl_q;
    eth_afu_pkg::mmio_rsp_t rsp_pl_q;

    always_ff @(posedge clk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            req_wr_q    <= 1'b0;
            req_rd_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            req_wr_q    <= req_in.wr_valid;
            req_rd_q    <= req_in.rd_valid;
            rsp_valid_q <= rsp_d.valid;
        end
    end

    always_ff @(posedge clk)
    begin
        req_pl_q <= req_in;
        rsp_pl_q <= rsp_d;
    end

    // Rebuild the structs with the reset strobes
    always_comb
    begin
        req_q          = req_pl_q;
        req_q.wr_valid = req_wr_q;
        req_q.rd_valid = req_rd_q;
        rsp_out        = rsp_pl_q;
        rsp_out.valid  = rsp_valid_q;
    end

endmodule

`default_nettype wire

//--- eth_afu_assert.sv
// ----------------------------------------
// Ethernet AFU protocol checks
// Read response timing, strobe width, reset
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module eth_afu_assert (
    input logic                   clk,
    input logic                   pck_cp2af_softReset_T1,
    input eth_afu_pkg::mmio_req_t mmio_req,
    input eth_afu_pkg::mmio_rsp_t mmio_rsp,
    input eth_afu_pkg::mac_req_t  mac_req,
    input logic                   init_done
);

    // Number of failed properties so far
    int fail_cnt = 0;

    // Every read answered on the fourth edge with its tid
    rd_answered: assert property (@(posedge clk) disable iff (pck_cp2af_softReset_T1)
        $past(mmio_req.rd_valid, 4) |-> mmio_rsp.valid && mmio_rsp.tid == $past(mmio_req.tid, 4))
        else
        begin
            $error("read request not answered four cycles later with its tid");
            fail_cnt++;
        end

    // No response without a read four edges back
    rsp_has_req: assert property (@(posedge clk) disable iff (pck_cp2af_softReset_T1)
        mmio_rsp.valid |-> $past(mmio_req.rd_valid, 4))
        else
        begin
            $error("response valid without a read request");
            fail_cnt++;
        end

    // MAC bank strobes last one cycle
    wr_single: assert property (@(posedge clk) disable iff (pck_cp2af_softReset_T1)
        mac_req.wr |=> !mac_req.wr)
        else
        begin
            $error("MAC write strobe longer than one cycle");
            fail_cnt++;
        end

    rd_single: assert property (@(posedge clk) disable iff (pck_cp2af_softReset_T1)
        mac_req.rd |=> !mac_req.rd)
        else
        begin
            $error("MAC read strobe longer than one cycle");
            fail_cnt++;
        end

    // Quiet outputs once reset has been seen for a full cycle
    reset_quiet: assert property (@(posedge clk)
        pck_cp2af_softReset_T1 && $past(pck_cp2af_softReset_T1) |->
            !mmio_rsp.valid && !mac_req.wr && !mac_req.rd && !init_done)
        else
        begin
            $error("outputs active during reset");
            fail_cnt++;
        end

endmodule

bind eth_afu_top eth_afu_assert u_assert (
    .clk                    (clk),
    .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
    .mmio_req               (mmio_req),
    .mmio_rsp               (mmio_rsp),
    .mac_req                (mac_req),
    .init_done              (init_done)
);

`default_nettype wire

//--- eth_afu_pkg.sv
// --------------------------------------
// Ethernet AFU shared definitions
// MMIO and MAC bus types, mailbox FSM states,
// CSR map and fixed register values
// --------------------------------------
`default_nettype none

package eth_afu_pkg;

    // Widths with a meaning
    typedef logic [15:0] mmio_addr_t;
    typedef logic [63:0] mmio_data_t;
    typedef logic [8:0]  mmio_tid_t;
    typedef logic [15:0] mac_addr_t;
    typedef logic [31:0] mac_data_t;

    // Host MMIO request, at most one valid bit high
    typedef struct packed {
        logic       wr_valid;
        logic       rd_valid;
        mmio_addr_t addr;
        mmio_tid_t  tid;
        mmio_data_t data;
    } mmio_req_t;

    // MMIO read response, tid echoed from the request
    typedef struct packed {
        logic       valid;
        mmio_tid_t  tid;
        mmio_data_t data;
    } mmio_rsp_t;

    // Single access on the MAC register bank
    typedef struct packed {
        logic      wr;
        logic      rd;
        mac_addr_t addr;
        mac_data_t wdata;
    } mac_req_t;

    // Mailbox control FSM
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_INIT,
        ST_ISSUE,
        ST_CAPTURE,
        ST_WAIT_CLEAR
    } eth_ctrl_state_t;

    // --------------------------------------
    // CSR byte offsets, slot in bits 6..3
    localparam mmio_addr_t CSR_DFH         = 16'h0000;
    localparam mmio_addr_t CSR_ID_L        = 16'h0008;
    localparam mmio_addr_t CSR_ID_H        = 16'h0010;
    localparam mmio_addr_t CSR_INIT        = 16'h0028;
    localparam mmio_addr_t CSR_ETH_CTRL    = 16'h0030;
    localparam mmio_addr_t CSR_ETH_WR_DATA = 16'h0038;
    localparam mmio_addr_t CSR_ETH_RD_DATA = 16'h0040;
    localparam mmio_addr_t CSR_SCRATCH     = 16'h0048;

    // Feature header and unit ID
    localparam mmio_data_t DFH_VALUE = 64'h1000_0000_0000_0001;
    localparam mmio_data_t AFU_ID_LO = 64'hB74F_291A_F34E_1783;
    localparam mmio_data_t AFU_ID_HI = 64'h0518_9FE4_0676_DD24;

    // Mailbox command bits, address sits in 15..0
    localparam int CTRL_WR_BIT = 16;
    localparam int CTRL_RD_BIT = 17;

endpackage

`default_nettype wire

//--- eth_afu_top.sv
// --------------------------------------
// Ethernet AFU control top
// MMIO boundary, CSRs, mailbox FSM, init timer
// and MAC register bank
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module eth_afu_top #(
    parameter int INIT_CYCLES  = 20,
    parameter int NUM_MAC_REGS = 16
) (
    input  logic                   clk,
    input  logic                   pck_cp2af_softReset_T1,
    input  eth_afu_pkg::mmio_req_t mmio_req,
    output eth_afu_pkg::mmio_rsp_t mmio_rsp
);

    // Boundary to CSR block
    eth_afu_pkg::mmio_req_t req_q;
    eth_afu_pkg::mmio_rsp_t rsp_d;

    // Mailbox between CSRs and FSM
    logic [31:0]            eth_ctrl;
    eth_afu_pkg::mac_data_t eth_wr_data;
    eth_afu_pkg::mac_data_t eth_rd_data;
    logic                   init_start;
    logic                   init_done;

    // FSM to MAC bank
    eth_afu_pkg::mac_req_t  mac_req;
    eth_afu_pkg::mac_data_t mac_rdata;

    ccip_mmio_reg u_mmio_reg (
        .clk                    (clk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .req_in                 (mmio_req),
        .req_q                  (req_q),
        .rsp_d                  (rsp_d),
        .rsp_out                (mmio_rsp)
    );

    afu_csr u_csr (
        .clk                    (clk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .req                    (req_q),
        .rsp                    (rsp_d),
        .eth_ctrl               (eth_ctrl),
        .eth_wr_data            (eth_wr_data),
        .eth_rd_data            (eth_rd_data),
        .init_start             (init_start),
        .init_done              (init_done)
    );

    eth_ctrl_fsm u_ctrl_fsm (
        .clk                    (clk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .eth_ctrl               (eth_ctrl),
        .eth_wr_data            (eth_wr_data),
        .init_done              (init_done),
        .mac_req                (mac_req),
        .mac_rdata              (mac_rdata),
        .eth_rd_data            (eth_rd_data)
    );

    init_timer #(
        .INIT_CYCLES            (INIT_CYCLES)
    ) u_init_timer (
        .clk                    (clk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .init_start             (init_start),
        .init_done              (init_done)
    );

    mac_csr_bank #(
        .NUM_MAC_REGS           (NUM_MAC_REGS)
    ) u_mac_bank (
        .clk                    (clk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .mac_req                (mac_req),
        .mac_rdata              (mac_rdata)
    );

endmodule

`default_nettype wire

//--- eth_ctrl_fsm.sv
// --------------------------------------
// Mailbox control FSM
// Turns mailbox command bits into single MAC
// bank accesses and captures read data
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module eth_ctrl_fsm (
    input  logic                   clk,
    input  logic                   pck_cp2af_softReset_T1,
    input  logic [31:0]            eth_ctrl,
    input  eth_afu_pkg::mac_data_t eth_wr_data,
    input  logic                   init_done,
    output eth_afu_pkg::mac_req_t  mac_req,
    input  eth_afu_pkg::mac_data_t mac_rdata,
    output eth_afu_pkg::mac_data_t eth_rd_data
);

    eth_afu_pkg::eth_ctrl_state_t state;

    // Command bits from software
    logic cmd_wr_bit;
    logic cmd_rd_bit;
    logic cmd_any;

    // Latched command, held while init is pending
    logic                   cmd_wr;
    logic                   cmd_rd;
    eth_afu_pkg::mac_addr_t cmd_addr;
    eth_afu_pkg::mac_data_t cmd_wdata;

    assign cmd_wr_bit = eth_ctrl[eth_afu_pkg::CTRL_WR_BIT];
    assign cmd_rd_bit = eth_ctrl[eth_afu_pkg::CTRL_RD_BIT];
    assign cmd_any    = cmd_wr_bit | cmd_rd_bit;

    // --------------------------------------
    // State and control
    always_ff @(posedge clk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            state       <= eth_afu_pkg::ST_IDLE;
            cmd_wr      <= 1'b0;
            cmd_rd      <= 1'b0;
            eth_rd_data <= '0;
        end
        else
        begin
            case (state)
                eth_afu_pkg::ST_IDLE:
                begin
                    // IDLE is entered only with both bits low, so any bit here is new
                    if (cmd_any)
                    begin
                        cmd_wr <= cmd_wr_bit;
                        // Write wins when both are set
                        cmd_rd <= cmd_rd_bit & ~cmd_wr_bit;
                        state  <= init_done ? eth_afu_pkg::ST_ISSUE
                                            : eth_afu_pkg::ST_WAIT_INIT;
                    end
                end
                eth_afu_pkg::ST_WAIT_INIT:
                    if (init_done)
                        state <= eth_afu_pkg::ST_ISSUE;
                eth_afu_pkg::ST_ISSUE:
                    state <= cmd_rd ? eth_afu_pkg::ST_CAPTURE : eth_afu_pkg::ST_WAIT_CLEAR;
                eth_afu_pkg::ST_CAPTURE:
                begin
                    // Bank data is registered, ready one cycle after the strobe
                    eth_rd_data <= mac_rdata;
                    state       <= eth_afu_pkg::ST_WAIT_CLEAR;
                end
                eth_afu_pkg::ST_WAIT_CLEAR:
                    if (!cmd_any)
                        state <= eth_afu_pkg::ST_IDLE;
                default:
                    state <= eth_afu_pkg::ST_IDLE;
            endcase
        end
    end

    // Address and write data captured with the command
    always_ff @(posedge clk)
    begin
        if (state == eth_afu_pkg::ST_IDLE && cmd_any)
        begin
            cmd_addr  <= eth_ctrl[15:0];
            cmd_wdata <= eth_wr_data;
        end
    end

    // Single cycle strobe while in ISSUE
    always_comb
    begin
        mac_req.wr    = (state == eth_afu_pkg::ST_ISSUE) & cmd_wr;
        mac_req.rd    = (state == eth_afu_pkg::ST_ISSUE) & cmd_rd;
        mac_req.addr  = cmd_addr;
        mac_req.wdata = cmd_wdata;
    end

endmodule

`default_nettype wire

//--- flist.f
eth_afu_pkg.sv
ccip_mmio_reg.sv
afu_csr.sv
eth_ctrl_fsm.sv
init_timer.sv
mac_csr_bank.sv
eth_afu_top.sv
eth_afu_assert.sv
tb_eth_afu.sv

//--- init_timer.sv
// --------------------------------------
// MAC bring-up timer
// Raises init_done a fixed time after init start
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module init_timer #(
    parameter int INIT_CYCLES = 20
) (
    input  logic clk,
    input  logic pck_cp2af_softReset_T1,
    input  logic init_start,
    output logic init_done
);

    localparam int CNT_W = $clog2(INIT_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_next;

    // Saturating count while started, cleared otherwise
    always_comb
    begin
        if (!init_start)
            cnt_next = '0;
        else if (cnt == CNT_W'(INIT_CYCLES))
            cnt_next = cnt;
        else
            cnt_next = cnt + CNT_W'(1);
    end

    always_ff @(posedge clk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            cnt       <= '0;
            init_done <= 1'b0;
        end
        else
        begin
            cnt       <= cnt_next;
            // Done on the edge the count reaches its end
            init_done <= init_start & (cnt_next == CNT_W'(INIT_CYCLES));
        end
    end

endmodule

`default_nettype wire

//--- mac_csr_bank.sv
// --------------------------------------
// MAC configuration register bank
// 32-bit registers, registered read data
// --------------------------------------
`timescale 1ns/1ns
`default_nettype none

module mac_csr_bank #(
    parameter int NUM_MAC_REGS = 16
) (
    input  logic                   clk,
    input  logic                   pck_cp2af_softReset_T1,
    input  eth_afu_pkg::mac_req_t  mac_req,
    output eth_afu_pkg::mac_data_t mac_rdata
);

    localparam int IDX_W = (NUM_MAC_REGS > 1) ? $clog2(NUM_MAC_REGS) : 1;

    eth_afu_pkg::mac_data_t regs [NUM_MAC_REGS];

    logic             in_range;
    logic [IDX_W-1:0] idx;

    // Addresses past the bank are dropped
    assign in_range = (mac_req.addr < eth_afu_pkg::mac_addr_t'(NUM_MAC_REGS));
    assign idx      = mac_req.addr[IDX_W-1:0];

    // --------------------------------------
    // Register writes
    always_ff @(posedge clk or posedge pck_cp2af_softReset_T1)
    begin
        if (pck_cp2af_softReset_T1)
        begin
            for (int i = 0; i < NUM_MAC_REGS; i++)
                regs[i] <= '0;
        end
        else if (mac_req.wr && in_range)
        begin
            regs[idx] <= mac_req.wdata;
        end
    end

    // Read returns next cycle, zero when out of range
    always_ff @(posedge clk)
    begin
        if (mac_req.rd)
            mac_rdata <= in_range ? regs[idx] : '0;
    end

endmodule

`default_nettype wire

//--- tb_eth_afu.sv
// ----------------------------------------
// Ethernet AFU control testbench
// MMIO driver tasks, MAC bank model and tests
// of CSRs, init timer and mailbox
// ----------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_eth_afu;

    localparam int INIT_CYCLES     = 20;
    localparam int NUM_MAC_REGS    = 16;
    localparam int RSP_LATENCY     = 4;
    localparam int RSP_TIMEOUT     = 16;
    // All tests take a few hundred cycles, margin on top
    localparam int WATCHDOG_CYCLES = 2000;

    logic                   clk;
    logic                   pck_cp2af_softReset_T1;
    eth_afu_pkg::mmio_req_t mmio_req;
    eth_afu_pkg::mmio_rsp_t mmio_rsp;

    // Cycle count and captured responses
    int                      cyc;
    int                      last_stamp;
    int                      last_addr;
    eth_afu_pkg::mmio_tid_t  next_tid;
    eth_afu_pkg::mmio_tid_t  rsp_tid_q [$];
    eth_afu_pkg::mmio_data_t rsp_data_q [$];
    int                      rsp_cyc_q [$];

    // Expected MAC bank contents, missing keys read as zero
    eth_afu_pkg::mac_data_t bank_model [int];

    eth_afu_top dut0 (
        .clk                    (clk),
        .pck_cp2af_softReset_T1 (pck_cp2af_softReset_T1),
        .mmio_req               (mmio_req),
        .mmio_rsp               (mmio_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
        cyc <= cyc + 1;

    // Responses sampled mid cycle, stamped with the edge count
    always @(negedge clk)
    begin
        if (!pck_cp2af_softReset_T1 && mmio_rsp.valid)
        begin
            rsp_tid_q.push_back(mmio_rsp.tid);
            rsp_data_q.push_back(mmio_rsp.data);
            rsp_cyc_q.push_back(cyc);
        end
    end

    // ----------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp)
        else
        begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // Bound protocol checks stop the run too
    always @(negedge clk)
    begin
        if (dut0.u_assert.fail_cnt != 0)
        begin
            $display("a bound protocol assertion failed");
            abort_run();
        end
    end

    // One request per rising edge, stamp taken mid cycle
    task automatic drive_req(input eth_afu_pkg::mmio_req_t r);
        @(posedge clk);
        mmio_req <= r;
        @(negedge clk);
        last_stamp = cyc;
    endtask

    task automatic mmio_write(input eth_afu_pkg::mmio_addr_t addr,
                              input eth_afu_pkg::mmio_data_t data);
        eth_afu_pkg::mmio_req_t r;
        r          = '0;
        r.wr_valid = 1'b1;
        r.addr     = addr;
        r.data     = data;
        drive_req(r);
        drive_req('0);
    endtask

    // Oldest response must carry this tid and land four edges on
    task automatic collect_rsp(input string name, input eth_afu_pkg::mmio_tid_t tid,
                               input int req_cyc, output eth_afu_pkg::mmio_data_t data);
        int waited;
        waited = 0;
        while (rsp_tid_q.size() == 0 && waited < RSP_TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (rsp_tid_q.size() == 0)
        begin
            $display("no read response for %s within %0d cycles", name, RSP_TIMEOUT);
            abort_run();
        end
        check_value({name, " tid"}, 64'(tid), 64'(rsp_tid_q[0]));
        check_value({name, " latency"}, 64'(RSP_LATENCY), 64'(rsp_cyc_q[0] - req_cyc));
        data = rsp_data_q.pop_front();
        void'(rsp_tid_q.pop_front());
        void'(rsp_cyc_q.pop_front());
    endtask

    task automatic mmio_read(input string name, input eth_afu_pkg::mmio_addr_t addr,
                             output eth_afu_pkg::mmio_data_t data);
        eth_afu_pkg::mmio_req_t r;
        int                     stamp;
        r          = '0;
        r.rd_valid = 1'b1;
        r.addr     = addr;
        r.tid      = next_tid;
        next_tid++;
        drive_req(r);
        stamp = last_stamp;
        drive_req('0);
        collect_rsp(name, r.tid, stamp, data);
    endtask

    task automatic read_expect(input string name, input eth_afu_pkg::mmio_addr_t addr,
                               input eth_afu_pkg::mmio_data_t exp);
        eth_afu_pkg::mmio_data_t data;
        mmio_read(name, addr, data);
        check_value(name, exp, data);
    endtask

    function automatic eth_afu_pkg::mac_data_t model_value(input int addr);
        if (addr < NUM_MAC_REGS && bank_model.exists(addr))
            return bank_model[addr];
        return '0;
    endfunction

    // Data, then address with write bit, then clear
    task automatic mailbox_write(input int addr, input eth_afu_pkg::mac_data_t data);
        mmio_write(eth_afu_pkg::CSR_ETH_WR_DATA, 64'(data));
        mmio_write(eth_afu_pkg::CSR_ETH_CTRL, 64'(addr) | (64'd1 << eth_afu_pkg::CTRL_WR_BIT));
        mmio_write(eth_afu_pkg::CSR_ETH_CTRL, 64'd0);
        // Bank drops addresses past its depth
        if (addr < NUM_MAC_REGS)
            bank_model[addr] = data;
    endtask

    // Address with read bit, then clear, then time for the capture
    task automatic mailbox_read_cmd(input int addr);
        mmio_write(eth_afu_pkg::CSR_ETH_CTRL, 64'(addr) | (64'd1 << eth_afu_pkg::CTRL_RD_BIT));
        mmio_write(eth_afu_pkg::CSR_ETH_CTRL, 64'd0);
        wait_cycles(10);
    endtask

    task automatic mailbox_read_expect(input string name, input int addr);
        mailbox_read_cmd(addr);
        read_expect(name, eth_afu_pkg::CSR_ETH_RD_DATA, 64'(model_value(addr)));
    endtask

    // ----------------------------------------
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial
    begin : main_seq
        eth_afu_pkg::mmio_req_t  r;
        eth_afu_pkg::mmio_data_t data;
        eth_afu_pkg::mmio_data_t scratch_val;
        eth_afu_pkg::mmio_addr_t burst_addr [4];
        eth_afu_pkg::mmio_data_t burst_exp [4];
        eth_afu_pkg::mac_data_t  old_val;
        eth_afu_pkg::mac_data_t  new_val;
        int                      stamps [4];
        int                      addr;

        pck_cp2af_softReset_T1 <= 1'b1;
        mmio_req               <= '0;
        next_tid = '0;
        void'($urandom(4994));
        repeat (10) @(posedge clk);
        pck_cp2af_softReset_T1 <= 1'b0;
        wait_cycles(2);

        // Constants after reset, unmapped slot and a quiet bus
        read_expect("dfh", eth_afu_pkg::CSR_DFH, eth_afu_pkg::DFH_VALUE);
        read_expect("id_lo", eth_afu_pkg::CSR_ID_L, eth_afu_pkg::AFU_ID_LO);
        read_expect("id_hi", eth_afu_pkg::CSR_ID_H, eth_afu_pkg::AFU_ID_HI);
        read_expect("unmapped", 16'h0018, 64'd0);
        wait_cycles(8);
        check_value("idle no response", 64'd0, 64'(rsp_tid_q.size()));

        // Scratch round trips
        for (int i = 0; i < 4; i++)
        begin
            scratch_val = {$urandom, $urandom};
            mmio_write(eth_afu_pkg::CSR_SCRATCH, scratch_val);
            read_expect("scratch", eth_afu_pkg::CSR_SCRATCH, scratch_val);
        end

        // Reads on consecutive edges, returned in order
        burst_addr[0] = eth_afu_pkg::CSR_DFH;
        burst_exp[0]  = eth_afu_pkg::DFH_VALUE;
        burst_addr[1] = eth_afu_pkg::CSR_SCRATCH;
        burst_exp[1]  = scratch_val;
        burst_addr[2] = eth_afu_pkg::CSR_ID_H;
        burst_exp[2]  = eth_afu_pkg::AFU_ID_HI;
        burst_addr[3] = 16'h0078;
        burst_exp[3]  = 64'd0;
        for (int i = 0; i < 4; i++)
        begin
            r          = '0;
            r.rd_valid = 1'b1;
            r.addr     = burst_addr[i];
            r.tid      = 9'(200 + i);
            drive_req(r);
            stamps[i] = last_stamp;
        end
        drive_req('0);
        for (int i = 0; i < 4; i++)
        begin
            collect_rsp("burst", 9'(200 + i), stamps[i], data);
            check_value("burst data", burst_exp[i], data);
        end

        // Init bring-up, bit 1 follows the timer
        mmio_write(eth_afu_pkg::CSR_INIT, 64'd1);
        read_expect("init pending", eth_afu_pkg::CSR_INIT, 64'h1);
        wait_cycles(INIT_CYCLES + 6);
        read_expect("init done", eth_afu_pkg::CSR_INIT, 64'h3);
        mmio_write(eth_afu_pkg::CSR_INIT, 64'd0);
        wait_cycles(3);
        read_expect("init cleared", eth_afu_pkg::CSR_INIT, 64'h0);
        mmio_write(eth_afu_pkg::CSR_INIT, 64'd1);
        wait_cycles(INIT_CYCLES + 6);

        // Mailbox write then read back over random addresses
        for (int i = 0; i < 6; i++)
        begin
            addr = $urandom % NUM_MAC_REGS;
            mailbox_write(addr, $urandom);
            mailbox_read_expect("mailbox", addr);
            last_addr = addr;
        end

        // Write held until init completes
        mmio_write(eth_afu_pkg::CSR_INIT, 64'd0);
        wait_cycles(3);
        old_val = model_value(last_addr);
        new_val = ~old_val;
        read_expect("rd data before write", eth_afu_pkg::CSR_ETH_RD_DATA, 64'(old_val));
        mailbox_write(last_addr, new_val);
        // Read command while the write still waits for init
        mailbox_read_cmd(last_addr);
        read_expect("rd data before init", eth_afu_pkg::CSR_ETH_RD_DATA, 64'(old_val));
        mmio_write(eth_afu_pkg::CSR_INIT, 64'd1);
        wait_cycles(INIT_CYCLES + 6);
        mailbox_read_expect("pending write", last_addr);

        // Past the bank depth, alias in range stays untouched
        addr = $urandom % NUM_MAC_REGS;
        mailbox_write(addr + NUM_MAC_REGS, $urandom);
        mailbox_read_expect("out of range", addr + NUM_MAC_REGS);
        mailbox_read_expect("alias intact", addr);

        if (dut0.u_assert.fail_cnt == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
        begin
            abort_run();
        end
    end

endmodule

`default_nettype wire
